// File: rtl/iq_defines.svh
// ========================================
// sizing macros for the memory-op issue slice
// include wherever queue or address-unit sizes are needed
// ========================================
`ifndef IQ_DEFINES_SVH
`define IQ_DEFINES_SVH

// ========================================
// issue queue
// ========================================

// number of queue slots, kept a power of two so slot pointers wrap freely
`define IQ_ENTRIES 8

// ========================================
// address generation
// ========================================

// number of address units fed by the selector
// unit 1 only receives grants when this is greater than 1
`define NUM_AGEN 2

// width of base, offset and generated address
`define ADDR_W 32

// width of the tag the outside world gives each operation
`define TAG_W 6

// cycles from the capture edge until done_addr is presented
`define AGEN_LAT 2

`endif

// File: rtl/iq_pkg.sv
// ========================================
// queue-side types: slot indices, slot vectors and operation kinds
// ========================================
`default_nettype none

`include "iq_defines.svh"

package iq_pkg;

	// index of one queue slot
	typedef logic [$clog2(`IQ_ENTRIES)-1:0] slot_idx_t;

	// one bit per slot, bit n describes slot n
	typedef logic [`IQ_ENTRIES-1:0] slot_vec_t;

	// slot indices listed oldest first, element 0 is the head
	typedef slot_idx_t [`IQ_ENTRIES-1:0] slot_list_t;

	// occupancy count, must reach IQ_ENTRIES itself
	typedef logic [$clog2(`IQ_ENTRIES+1)-1:0] iq_count_t;

	// only loads and stores go to the address units
	// sync entries act as barriers and alu entries just drain at the head
	typedef enum logic [1:0] {
		op_load  = 2'd0,
		op_store = 2'd1,
		op_sync  = 2'd2,
		op_alu   = 2'd3
	} op_kind_t;

	// true for kinds that need an address
	function automatic logic is_mem(input op_kind_t kind);
		return (kind == op_load) || (kind == op_store);
	endfunction

	// turns a one-hot grant into a slot index, zero for an empty grant
	function automatic slot_idx_t onehot_to_idx(input slot_vec_t vec);
		slot_idx_t idx;
		idx = '0;
		for (int i = 0; i < `IQ_ENTRIES; i++) begin
			if (vec[i])
				idx = slot_idx_t'(i);
		end
		return idx;
	endfunction

endpackage

`default_nettype wire

// File: rtl/agen_pkg.sv
// ========================================
// address-side types shared by dispatch, queue and address units
// ========================================
`default_nettype none

`include "iq_defines.svh"

package agen_pkg;

	// a memory address, also used for base and offset operands
	typedef logic [`ADDR_W-1:0] addr_t;

	// identifier that travels with an operation from dispatch to done
	typedef logic [`TAG_W-1:0] tag_t;

	// down-counter that times one operation through an address unit
	typedef logic [$clog2(`AGEN_LAT+1)-1:0] agen_cnt_t;

	// load value for the counter at the capture edge
	// done fires on the edge where the counter is already zero
	localparam agen_cnt_t AGEN_CNT_START = agen_cnt_t'(`AGEN_LAT - 1);

	// effective address, wraps modulo 2**ADDR_W
	function automatic addr_t calc_addr(input addr_t base, input addr_t offset);
		return base + offset;
	endfunction

endpackage

`default_nettype wire

// File: rtl/dispatch_unit.sv
// ========================================
// dispatch stage, turns incoming operations into queue writes at the tail
// drops strobes while the queue reports full
// ========================================
`default_nettype none

module dispatch_unit
	import iq_pkg::*;
	import agen_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire logic      dispatch_valid,
	input  wire op_kind_t  dispatch_kind,
	input  wire tag_t      dispatch_tag,
	input  wire addr_t     dispatch_base,
	input  wire addr_t     dispatch_offset,
	input  wire logic      dispatch_ready,
	input  wire logic      full,
	output logic           alloc_valid,
	output slot_idx_t      alloc_slot,
	output op_kind_t       alloc_kind,
	output tag_t           alloc_tag,
	output addr_t          alloc_base,
	output addr_t          alloc_offset,
	output logic           alloc_ready
);

	// next slot to be written, the queue tracks the head and the count
	slot_idx_t tail_q;

	// a strobe is only taken while there is room
	// the caller is not supposed to strobe when full, this just keeps the queue safe
	assign alloc_valid  = dispatch_valid && !full;
	assign alloc_slot   = tail_q;
	assign alloc_kind   = dispatch_kind;
	assign alloc_tag    = dispatch_tag;
	assign alloc_base   = dispatch_base;
	assign alloc_offset = dispatch_offset;

	// sync and alu entries wait on no operand, so they enter the queue ready
	assign alloc_ready = dispatch_ready || !is_mem(dispatch_kind);

	// tail moves only on accepted writes and wraps with the slot index width
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tail_q <= '0;
		end else if (alloc_valid) begin
			tail_q <= tail_q + slot_idx_t'(1);
		end
	end

endmodule

`default_nettype wire

// File: rtl/issue_queue.sv
// ========================================
// circular issue queue with readiness, age order and older-barrier tracking
// entries enter at the dispatch tail and retire in order from the head
// ========================================
`default_nettype none

`include "iq_defines.svh"

module issue_queue
	import iq_pkg::*;
	import agen_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       alloc_valid,
	input  wire slot_idx_t  alloc_slot,
	input  wire op_kind_t   alloc_kind,
	input  wire tag_t       alloc_tag,
	input  wire addr_t      alloc_base,
	input  wire addr_t      alloc_offset,
	input  wire logic       alloc_ready,
	input  wire logic       wakeup_valid,
	input  wire tag_t       wakeup_tag,
	input  wire slot_vec_t  issue0,
	input  wire slot_vec_t  issue1,
	input  wire logic       done0,
	input  wire slot_idx_t  done_slot0,
	input  wire logic       done1,
	input  wire slot_idx_t  done_slot1,
	output logic            full,
	output slot_list_t      heads,
	output slot_vec_t       could_issue,
	output slot_vec_t       iq_mem,
	output slot_vec_t       prior_sync,
	output slot_vec_t       prior_valid,
	output tag_t            issue_tag0,
	output addr_t           issue_base0,
	output addr_t           issue_offset0,
	output slot_idx_t       issue_slot0,
	output tag_t            issue_tag1,
	output addr_t           issue_base1,
	output addr_t           issue_offset1,
	output slot_idx_t       issue_slot1
);

	// ========================================
	// slot state
	// ========================================

	// control flags, one bit per slot
	slot_vec_t valid_q;
	slot_vec_t ready_q;
	slot_vec_t issued_q;
	slot_vec_t complete_q;

	// payload written at dispatch and read at issue
	op_kind_t kind_q   [`IQ_ENTRIES];
	tag_t     tag_q    [`IQ_ENTRIES];
	addr_t    base_q   [`IQ_ENTRIES];
	addr_t    offset_q [`IQ_ENTRIES];

	slot_idx_t head_q;
	iq_count_t count_q;

	// running flags while walking from the head
	logic older_sync;
	logic older_valid;

	// head leaves this cycle
	logic head_done;
	logic retire;

	assign full = (count_q == iq_count_t'(`IQ_ENTRIES));

	// ========================================
	// age order and eligibility vectors
	// ========================================
	always_comb begin
		older_sync  = 1'b0;
		older_valid = 1'b0;
		prior_sync  = '0;
		prior_valid = '0;
		for (int n = 0; n < `IQ_ENTRIES; n++) begin
			heads[n] = head_q + slot_idx_t'(n);
			// each slot sees only what lies strictly between it and the head
			prior_sync[heads[n]]  = older_sync;
			prior_valid[heads[n]] = older_valid;
			older_sync  = older_sync || (valid_q[heads[n]] && kind_q[heads[n]] == op_sync);
			older_valid = older_valid || valid_q[heads[n]];
		end
	end

	always_comb begin
		for (int i = 0; i < `IQ_ENTRIES; i++) begin
			could_issue[i] = valid_q[i] && ready_q[i] && !issued_q[i];
			iq_mem[i]      = valid_q[i] && is_mem(kind_q[i]);
		end
	end

	// grants are one-hot, so the slot index picks the operands straight out
	assign issue_slot0   = onehot_to_idx(issue0);
	assign issue_tag0    = tag_q[issue_slot0];
	assign issue_base0   = base_q[issue_slot0];
	assign issue_offset0 = offset_q[issue_slot0];
	assign issue_slot1   = onehot_to_idx(issue1);
	assign issue_tag1    = tag_q[issue_slot1];
	assign issue_base1   = base_q[issue_slot1];
	assign issue_offset1 = offset_q[issue_slot1];

	// a done pulse aimed at the head lets it retire on the same edge that
	// records completion
	assign head_done = complete_q[head_q] || (done0 && done_slot0 == head_q)
		|| (done1 && done_slot1 == head_q);
	assign retire = valid_q[head_q] && (head_done || !is_mem(kind_q[head_q]));

	// ========================================
	// control update
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q    <= '0;
			ready_q    <= '0;
			issued_q   <= '0;
			complete_q <= '0;
			head_q     <= '0;
			count_q    <= '0;
		end else begin
			// broadcast wakeup marks every waiting entry with that tag
			for (int i = 0; i < `IQ_ENTRIES; i++) begin
				if (wakeup_valid && valid_q[i] && tag_q[i] == wakeup_tag)
					ready_q[i] <= 1'b1;
			end
			issued_q <= issued_q | issue0 | issue1;
			if (done0)
				complete_q[done_slot0] <= 1'b1;
			if (done1)
				complete_q[done_slot1] <= 1'b1;
			if (retire) begin
				valid_q[head_q] <= 1'b0;
				head_q <= head_q + slot_idx_t'(1);
			end
			// a new entry clears whatever the previous occupant left behind
			if (alloc_valid) begin
				valid_q[alloc_slot]    <= 1'b1;
				ready_q[alloc_slot]    <= alloc_ready
					|| (wakeup_valid && wakeup_tag == alloc_tag);
				issued_q[alloc_slot]   <= 1'b0;
				complete_q[alloc_slot] <= 1'b0;
			end
			case ({alloc_valid, retire})
				2'b10:   count_q <= count_q + iq_count_t'(1);
				2'b01:   count_q <= count_q - iq_count_t'(1);
				default: count_q <= count_q;
			endcase
		end
	end

	// payload follows the write port only
	always_ff @(posedge clk) begin
		if (alloc_valid) begin
			kind_q[alloc_slot]   <= alloc_kind;
			tag_q[alloc_slot]    <= alloc_tag;
			base_q[alloc_slot]   <= alloc_base;
			offset_q[alloc_slot] <= alloc_offset;
		end
	end

endmodule

`default_nettype wire

// File: rtl/agen_issue.sv
// ========================================
// picks the oldest eligible memory entries for the two address units
// purely combinational, the units capture the grants at the next edge
// ========================================
`default_nettype none

`include "iq_defines.svh"

module agen_issue
	import iq_pkg::*;
(
	input  wire logic       agen0_idle,
	input  wire logic       agen1_idle,
	input  wire slot_list_t heads,
	input  wire slot_vec_t  could_issue,
	input  wire slot_vec_t  iq_mem,
	input  wire slot_vec_t  prior_sync,
	input  wire slot_vec_t  prior_valid,
	output slot_vec_t       issue0,
	output slot_vec_t       issue1
);

	// per-slot eligibility, independent of which unit takes it
	slot_vec_t eligible;

	always_comb begin
		for (int i = 0; i < `IQ_ENTRIES; i++) begin
			// a sync only blocks when something older is actually still there
			eligible[i] = could_issue[i] && iq_mem[i]
				&& (!prior_sync[i] || !prior_valid[i]);
		end
	end

	always_comb begin
		issue0 = '0;
		issue1 = '0;

		// unit 0 gets the first eligible slot counting from the head
		if (agen0_idle) begin
			for (int n = 0; n < `IQ_ENTRIES; n++) begin
				if (eligible[heads[n]] && issue0 == '0)
					issue0[heads[n]] = 1'b1;
			end
		end

		// unit 1 gets the next one, skipping whatever unit 0 just took
		// when unit 0 is busy unit 1 may end up with the oldest
		if (agen1_idle && `NUM_AGEN > 1) begin
			for (int n = 0; n < `IQ_ENTRIES; n++) begin
				if (eligible[heads[n]] && !issue0[heads[n]] && issue1 == '0)
					issue1[heads[n]] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/agen_unit.sv
// ========================================
// fixed-latency address adder holding one operation at a time
// start is a capture strobe and done a one-cycle result pulse
// ========================================
`default_nettype none

module agen_unit
	import iq_pkg::*;
	import agen_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire logic      start,
	input  wire tag_t      start_tag,
	input  wire addr_t     start_base,
	input  wire addr_t     start_offset,
	input  wire slot_idx_t start_slot,
	output logic           idle,
	output logic           done,
	output tag_t           done_tag,
	output addr_t          done_addr,
	output slot_idx_t      done_slot
);

	logic      busy_q;
	logic      done_q;
	agen_cnt_t cnt_q;

	// operation in flight, sum is formed at capture and held until done
	tag_t      tag_q;
	addr_t     addr_q;
	slot_idx_t slot_q;

	// the selector never grants a busy unit, so start is only seen while idle
	assign idle      = !busy_q;
	assign done      = done_q;
	assign done_tag  = tag_q;
	assign done_addr = addr_q;
	assign done_slot = slot_q;

	// counter runs AGEN_LAT-1 down to zero, done follows the edge at zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else begin
			done_q <= 1'b0;
			if (busy_q) begin
				if (cnt_q == '0) begin
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end else begin
					cnt_q <= cnt_q - agen_cnt_t'(1);
				end
			end else if (start) begin
				busy_q <= 1'b1;
				cnt_q  <= AGEN_CNT_START;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy_q) begin
			tag_q  <= start_tag;
			addr_q <= calc_addr(start_base, start_offset);
			slot_q <= start_slot;
		end
	end

endmodule

`default_nettype wire

// File: rtl/lsq_agen_top.sv
// ========================================
// memory-op issue slice, dispatch into the queue and out to two address units
// ========================================
`default_nettype none

module lsq_agen_top
	import iq_pkg::*;
	import agen_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire logic     dispatch_valid,
	input  wire op_kind_t dispatch_kind,
	input  wire tag_t     dispatch_tag,
	input  wire addr_t    dispatch_base,
	input  wire addr_t    dispatch_offset,
	input  wire logic     dispatch_ready,
	input  wire logic     wakeup_valid,
	input  wire tag_t     wakeup_tag,
	output logic          full,
	output logic          done0,
	output tag_t          done_tag0,
	output addr_t         done_addr0,
	output logic          done1,
	output tag_t          done_tag1,
	output addr_t         done_addr1
);

	// ========================================
	// interconnect
	// ========================================

	// dispatch to queue write port
	logic      alloc_valid;
	slot_idx_t alloc_slot;
	op_kind_t  alloc_kind;
	tag_t      alloc_tag;
	addr_t     alloc_base;
	addr_t     alloc_offset;
	logic      alloc_ready;

	// queue to selector
	slot_list_t heads;
	slot_vec_t  could_issue;
	slot_vec_t  iq_mem;
	slot_vec_t  prior_sync;
	slot_vec_t  prior_valid;

	// selector grants and the operands they pull from the queue
	slot_vec_t issue0;
	slot_vec_t issue1;
	tag_t      issue_tag0;
	addr_t     issue_base0;
	addr_t     issue_offset0;
	slot_idx_t issue_slot0;
	tag_t      issue_tag1;
	addr_t     issue_base1;
	addr_t     issue_offset1;
	slot_idx_t issue_slot1;

	// unit status back into the slice
	logic      agen0_idle;
	logic      agen1_idle;
	slot_idx_t done_slot0;
	slot_idx_t done_slot1;

	dispatch_unit u_dispatch (
		.clk, .rst_n,
		.dispatch_valid, .dispatch_kind, .dispatch_tag,
		.dispatch_base, .dispatch_offset, .dispatch_ready, .full,
		.alloc_valid, .alloc_slot, .alloc_kind, .alloc_tag,
		.alloc_base, .alloc_offset, .alloc_ready
	);

	issue_queue u_iq (
		.clk, .rst_n,
		.alloc_valid, .alloc_slot, .alloc_kind, .alloc_tag,
		.alloc_base, .alloc_offset, .alloc_ready,
		.wakeup_valid, .wakeup_tag, .issue0, .issue1,
		.done0, .done_slot0, .done1, .done_slot1,
		.full, .heads, .could_issue, .iq_mem, .prior_sync, .prior_valid,
		.issue_tag0, .issue_base0, .issue_offset0, .issue_slot0,
		.issue_tag1, .issue_base1, .issue_offset1, .issue_slot1
	);

	agen_issue u_sel (
		.agen0_idle, .agen1_idle, .heads, .could_issue, .iq_mem,
		.prior_sync, .prior_valid, .issue0, .issue1
	);

	// ========================================
	// address units, each started by any bit of its grant
	// ========================================
	agen_unit u_agen0 (
		.clk, .rst_n,
		.start(|issue0), .start_tag(issue_tag0), .start_base(issue_base0),
		.start_offset(issue_offset0), .start_slot(issue_slot0),
		.idle(agen0_idle), .done(done0), .done_tag(done_tag0),
		.done_addr(done_addr0), .done_slot(done_slot0)
	);

	agen_unit u_agen1 (
		.clk, .rst_n,
		.start(|issue1), .start_tag(issue_tag1), .start_base(issue_base1),
		.start_offset(issue_offset1), .start_slot(issue_slot1),
		.idle(agen1_idle), .done(done1), .done_tag(done_tag1),
		.done_addr(done_addr1), .done_slot(done_slot1)
	);

endmodule

`default_nettype wire

// File: dv/lsq_agen_checker.sv
// ========================================
// concurrent checks on grants, unit occupancy and done timing
// bound into issue_queue by the testbench
// ========================================
`default_nettype none

`include "iq_defines.svh"

module lsq_agen_checker
	import iq_pkg::*;
(
	input wire logic      clk,
	input wire logic      rst_n,
	input wire slot_vec_t issue0,
	input wire slot_vec_t issue1,
	input wire logic      done0,
	input wire logic      done1,
	input wire slot_vec_t could_issue,
	input wire slot_vec_t iq_mem,
	input wire slot_vec_t prior_sync,
	input wire slot_vec_t prior_valid
);

	// grant history per unit, bit 0 holds the grant of the previous cycle
	// a unit is busy while a grant sits in the low AGEN_LAT bits
	logic [`AGEN_LAT:0] grant_hist0;
	logic [`AGEN_LAT:0] grant_hist1;

	// slots the selector may legally pick this cycle
	slot_vec_t eligible;

	// failure counts, read by the testbench for its closing line
	int fail_onehot = 0;
	int fail_idle = 0;
	int fail_elig = 0;
	int fail_done = 0;

	// a sync only blocks a younger entry while something older is still valid
	assign eligible = could_issue & iq_mem & (~prior_sync | ~prior_valid);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant_hist0 <= '0;
			grant_hist1 <= '0;
		end else begin
			grant_hist0 <= {grant_hist0[`AGEN_LAT-1:0], |issue0};
			grant_hist1 <= {grant_hist1[`AGEN_LAT-1:0], |issue1};
		end
	end

	// each grant names at most one slot and the two units never share one
	assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(issue0) && $onehot0(issue1) && ((issue0 & issue1) == '0))
		else begin
			$error("grant vectors overlap or are not one-hot");
			fail_onehot = fail_onehot + 1;
		end

	// a unit still working on an earlier grant gets nothing new
	assert property (@(posedge clk) disable iff (!rst_n)
		!((|grant_hist0[`AGEN_LAT-1:0]) && (issue0 != '0))
		&& !((|grant_hist1[`AGEN_LAT-1:0]) && (issue1 != '0)))
		else begin
			$error("grant given to a unit that is not idle");
			fail_idle = fail_idle + 1;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		((issue0 | issue1) & ~eligible) == '0)
		else begin
			$error("grant given to a slot that is not eligible");
			fail_elig = fail_elig + 1;
		end

	// done pulses exactly AGEN_LAT cycles after the capture edge and never otherwise
	assert property (@(posedge clk) disable iff (!rst_n)
		(done0 == grant_hist0[`AGEN_LAT]) && (done1 == grant_hist1[`AGEN_LAT]))
		else begin
			$error("done does not follow its grant by the address latency");
			fail_done = fail_done + 1;
		end

endmodule

`default_nettype wire

// File: dv/lsq_agen_tb.sv
// ========================================
// table-driven testbench for the memory-op issue slice
// table sections run in turn and each is drained before the next
// ========================================
`default_nettype none

`include "iq_defines.svh"

module lsq_agen_tb
	import iq_pkg::*;
	import agen_pkg::*;
();

	localparam int NUM_ROWS = 22;
	localparam int NUM_TAGS = 1 << `TAG_W;

	logic     clk;
	logic     rst_n;
	logic     dispatch_valid;
	op_kind_t dispatch_kind;
	tag_t     dispatch_tag;
	addr_t    dispatch_base;
	addr_t    dispatch_offset;
	logic     dispatch_ready;
	logic     wakeup_valid;
	tag_t     wakeup_tag;
	logic     full;
	logic     done0;
	tag_t     done_tag0;
	addr_t    done_addr0;
	logic     done1;
	tag_t     done_tag1;
	addr_t    done_addr1;

	// ========================================
	// stimulus table, one row per operation
	// ========================================

	// wake, lat and unit are cycles or unit numbers, -1 when they do not apply
	// lat counts from the dispatch strobe cycle to the done cycle
	string    row_name  [NUM_ROWS];
	int       row_sect  [NUM_ROWS];
	op_kind_t row_kind  [NUM_ROWS];
	tag_t     row_tag   [NUM_ROWS];
	addr_t    row_base  [NUM_ROWS];
	addr_t    row_off   [NUM_ROWS];
	logic     row_ready [NUM_ROWS];
	int       row_wake  [NUM_ROWS];
	int       row_lat   [NUM_ROWS];
	int       row_unit  [NUM_ROWS];
	logic     row_full  [NUM_ROWS];
	addr_t    row_exp   [NUM_ROWS];
	int       nrows = 0;

	// reference model, indexed by tag since every tag is used once per run
	bit       sent      [NUM_TAGS];
	int       seen      [NUM_TAGS];
	int       disp_cyc  [NUM_TAGS];
	int       row_of_tag[NUM_TAGS];
	int       sent_cnt = 0;
	int       done_cnt = 0;

	int       cyc = 0;
	int       seq_errors = 0;
	int       mon_errors = 0;
	int       chk_errors;
	integer   seed;

	lsq_agen_top DUT (
		.clk, .rst_n,
		.dispatch_valid, .dispatch_kind, .dispatch_tag,
		.dispatch_base, .dispatch_offset, .dispatch_ready,
		.wakeup_valid, .wakeup_tag, .full,
		.done0, .done_tag0, .done_addr0,
		.done1, .done_tag1, .done_addr1
	);

	bind issue_queue lsq_agen_checker u_checker (
		.clk, .rst_n, .issue0, .issue1, .done0, .done1,
		.could_issue, .iq_mem, .prior_sync, .prior_valid
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// cycle number as seen at the falling edge
	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic add_row(input string name, input int sect, input op_kind_t kind,
		input int tag, input logic ready, input int wake, input int lat, input int unit,
		input logic full_after);
		row_name[nrows]  = name;
		row_sect[nrows]  = sect;
		row_kind[nrows]  = kind;
		row_tag[nrows]   = tag_t'(tag);
		row_ready[nrows] = ready;
		row_wake[nrows]  = wake;
		row_lat[nrows]   = lat;
		row_unit[nrows]  = unit;
		row_full[nrows]  = full_after;
		row_base[nrows]  = $random(seed);
		row_off[nrows]   = $random(seed);
		// the sum wraps at the address width
		row_exp[nrows]   = row_base[nrows] + row_off[nrows];
		row_of_tag[tag]  = nrows;
		nrows = nrows + 1;
	endtask

	task automatic build_table();
		int i;
		// a lone ready load on an empty queue with both units idle
		add_row("single_load", 0, op_load, 1, 1'b1, -1, 4, 0, 1'b0);
		// the head waits for its wakeup and a sync holds back the pair behind it
		// once the sync retires the pair leaves on both units in one cycle
		add_row("blocked_head", 1, op_load, 2, 1'b0, 3, 7, 0, 1'b0);
		add_row("sync_barrier", 1, op_sync, 3, 1'b1, -1, -1, -1, 1'b0);
		add_row("after_sync_a", 1, op_load, 4, 1'b1, -1, 10, 0, 1'b0);
		add_row("after_sync_b", 1, op_store, 5, 1'b1, -1, 9, 1, 1'b0);
		// younger ready operations overtake a load that still waits
		add_row("late_load", 2, op_load, 6, 1'b0, 6, 10, 0, 1'b0);
		add_row("young_c", 2, op_load, 7, 1'b1, -1, 4, 0, 1'b0);
		add_row("young_d", 2, op_store, 8, 1'b1, -1, 4, 1, 1'b0);
		add_row("plain_alu", 2, op_alu, 9, 1'b1, -1, -1, -1, 1'b0);
		// waiting loads in every slot, woken one per cycle afterwards
		for (i = 0; i < `IQ_ENTRIES; i++) begin
			add_row($sformatf("fill_%0d", i), 3, op_load, 10 + i, 1'b0, 10 + i,
				-1, -1, i == `IQ_ENTRIES - 1);
		end
		// mixed kinds with a sync in the middle
		add_row("mix_store", 4, op_store, 18, 1'b1, -1, 4, 0, 1'b0);
		add_row("mix_alu", 4, op_alu, 19, 1'b1, -1, -1, -1, 1'b0);
		add_row("mix_sync", 4, op_sync, 20, 1'b1, -1, -1, -1, 1'b0);
		add_row("mix_store_b", 4, op_store, 21, 1'b1, -1, 7, 0, 1'b0);
		add_row("mix_load", 4, op_load, 22, 1'b1, -1, 6, 1, 1'b0);
	endtask

	// ========================================
	// stimulus
	// ========================================

	// one row per cycle, wakeups at their offsets from the first strobe
	task automatic run_section(input int first, input int last);
		int t;
		int r;
		int n;
		int last_wake;
		n = last - first;
		last_wake = -1;
		for (r = first; r < last; r++) begin
			if (row_wake[r] > last_wake)
				last_wake = row_wake[r];
		end
		t = 0;
		while (t <= n || t <= last_wake) begin
			@(posedge clk);
			if (t < n) begin
				r = first + t;
				dispatch_valid  <= 1'b1;
				dispatch_kind   <= row_kind[r];
				dispatch_tag    <= row_tag[r];
				dispatch_base   <= row_base[r];
				dispatch_offset <= row_off[r];
				dispatch_ready  <= row_ready[r];
				if (row_kind[r] == op_load || row_kind[r] == op_store) begin
					sent[row_tag[r]] = 1'b1;
					sent_cnt = sent_cnt + 1;
				end
			end else begin
				dispatch_valid <= 1'b0;
			end
			wakeup_valid <= 1'b0;
			for (r = first; r < last; r++) begin
				if (row_wake[r] == t) begin
					wakeup_valid <= 1'b1;
					wakeup_tag   <= row_tag[r];
				end
			end
			// full now reflects every row up to the previous one
			@(negedge clk);
			if (t > 0 && t <= n && full !== row_full[first + t - 1]) begin
				$display("MISMATCH %s full expected %0b actual %0b",
					row_name[first + t - 1], row_full[first + t - 1], full);
				seq_errors = seq_errors + 1;
			end
			t = t + 1;
		end
		@(posedge clk);
		dispatch_valid <= 1'b0;
		wakeup_valid   <= 1'b0;
	endtask

	task automatic drain();
		while (done_cnt != sent_cnt)
			@(posedge clk);
		// leftover entries retire from the head at one per cycle
		repeat (`IQ_ENTRIES + 2)
			@(posedge clk);
		@(negedge clk);
		if (full !== 1'b0) begin
			$display("full is still high after the queue drained");
			seq_errors = seq_errors + 1;
		end
	endtask

	// ========================================
	// completion monitor
	// ========================================
	task automatic check_done(input int unit, input tag_t tag, input addr_t addr);
		int r;
		r = row_of_tag[tag];
		if (!sent[tag] || seen[tag] != 0) begin
			$display("completion on unit %0d for tag %0d that was not outstanding",
				unit, tag);
			mon_errors = mon_errors + 1;
		end else begin
			if (addr !== row_exp[r]) begin
				$display("MISMATCH %s address expected %h actual %h",
					row_name[r], row_exp[r], addr);
				mon_errors = mon_errors + 1;
			end
			if (row_unit[r] >= 0 && unit != row_unit[r]) begin
				$display("MISMATCH %s unit expected %0d actual %0d",
					row_name[r], row_unit[r], unit);
				mon_errors = mon_errors + 1;
			end
			if (row_lat[r] >= 0 && cyc - disp_cyc[tag] != row_lat[r]) begin
				$display("MISMATCH %s latency expected %0d actual %0d",
					row_name[r], row_lat[r], cyc - disp_cyc[tag]);
				mon_errors = mon_errors + 1;
			end
			done_cnt = done_cnt + 1;
		end
		seen[tag] = seen[tag] + 1;
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			if (dispatch_valid)
				disp_cyc[dispatch_tag] = cyc;
			if (done0)
				check_done(0, done_tag0, done_addr0);
			if (done1)
				check_done(1, done_tag1, done_addr1);
		end
	end

	// ========================================
	// main sequence and watchdog
	// ========================================
	initial begin
		int s;
		int e;
		seed = 59237;
		rst_n = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_kind = op_alu;
		dispatch_tag = '0;
		dispatch_base = '0;
		dispatch_offset = '0;
		dispatch_ready = 1'b0;
		wakeup_valid = 1'b0;
		wakeup_tag = '0;
		build_table();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		s = 0;
		while (s < nrows) begin
			e = s;
			while (e < nrows && row_sect[e] == row_sect[s])
				e = e + 1;
			run_section(s, e);
			drain();
			s = e;
		end
		chk_errors = DUT.u_iq.u_checker.fail_onehot + DUT.u_iq.u_checker.fail_idle
			+ DUT.u_iq.u_checker.fail_elig + DUT.u_iq.u_checker.fail_done;
		$display("errors %0d (sequence %0d, monitor %0d, assertions %0d)",
			seq_errors + mon_errors + chk_errors, seq_errors, mon_errors, chk_errors);
		if (seq_errors + mon_errors + chk_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// each row gets a generous budget of cycles
	initial begin
		repeat (NUM_ROWS * 20) @(posedge clk);
		$display("timeout after %0d cycles with %0d operations still outstanding",
			NUM_ROWS * 20, sent_cnt - done_cnt);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/iq_pkg.sv
rtl/agen_pkg.sv
rtl/dispatch_unit.sv
rtl/issue_queue.sv
rtl/agen_issue.sv
rtl/agen_unit.sv
rtl/lsq_agen_top.sv
dv/lsq_agen_checker.sv
dv/lsq_agen_tb.sv

// File: Makefile
# Verilator build and run for the memory-op issue slice

VERILATOR ?= verilator
TOP       ?= lsq_agen_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
